/* logic/udp_tx_pkg.sv */
`default_nettype none

package udp_tx_pkg;

  //////////////////////////////////////////////////////////////////////
  // lengths and fixed field values
  //////////////////////////////////////////////////////////////////////

  localparam logic [15:0] udp_hdr_len    = 16'd8;
  localparam logic [15:0] ipv4_hdr_len   = 16'd20;
  localparam logic [3:0]  ipv4_ver       = 4'd4;
  localparam logic [3:0]  ipv4_ihl       = 4'd5;
  localparam logic [7:0]  ipv4_ttl       = 8'd128;
  localparam logic [7:0]  ipv4_proto_udp = 8'd17;

  // 16-bit words covered by the header checksum
  localparam int          hdr_words      = 10;

  // keeps the datagram inside a 1500 byte IP packet
  localparam logic [15:0] max_pld_len    = 16'd1472;

  //////////////////////////////////////////////////////////////////////
  // header layouts, first byte on the wire is the msb
  //////////////////////////////////////////////////////////////////////

  typedef logic [3:0][7:0] ipv4_addr_t;

  typedef struct packed {
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [15:0] length;
    logic [15:0] chksum;
  } udp_hdr_t;

  typedef struct packed {
    logic [3:0]  ver;
    logic [3:0]  ihl;
    logic [7:0]  qos;
    logic [15:0] length;
    logic [15:0] id;
    logic [15:0] flags_fo;
    logic [7:0]  ttl;
    logic [7:0]  proto;
    logic [15:0] chksum;
    ipv4_addr_t  src_ip;
    ipv4_addr_t  dst_ip;
  } ipv4_hdr_t;

  // empty payloads and oversize datagrams are refused at start
  function automatic logic pld_len_ok(input logic [15:0] len);
    return (len != 16'd0) && (len <= max_pld_len);
  endfunction

endpackage : udp_tx_pkg

`default_nettype wire

/* logic/byte_strm_if.sv */
`default_nettype none

interface byte_strm_if;

  logic [7:0] dat;
  logic       val;
  logic       sof;
  logic       eof;

  // producer side
  modport src (
    output dat,
    output val,
    output sof,
    output eof
  );

  // consumer side
  modport snk (
    input dat,
    input val,
    input sof,
    input eof
  );

endinterface : byte_strm_if

`default_nettype wire

/* logic/hdr_serializer.sv */
`default_nettype none

module hdr_serializer #(
  parameter type hdr_t = logic [7:0]
) (
  input  logic       clk,
  input  logic       fsm_rst,
  input  logic       load,
  input  hdr_t       hdr,
  input  logic       shift,
  output logic [7:0] dat
);

  logic [$bits(hdr_t)-1:0] sr;

  // load wins over shift, zeros fill in from the bottom
  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      sr <= '0;
    end
    else if (load) begin
      sr <= hdr;
    end
    else if (shift) begin
      sr <= {sr[$bits(hdr_t)-9:0], 8'h00};
    end
  end

  // leading byte always visible
  assign dat = sr[$bits(hdr_t)-1 -: 8];

endmodule : hdr_serializer

`default_nettype wire

/* logic/udp_tx.sv */
`default_nettype none

module udp_tx
  import udp_tx_pkg::*;
(
  input  logic        clk,
  input  logic        fsm_rst,
  input  logic        start,
  input  logic [15:0] src_port,
  input  logic [15:0] dst_port,
  input  logic [15:0] pld_len,
  input  logic [7:0]  pld_dat,
  input  logic        udp_go,
  output logic        busy,
  output logic        udp_rdy,
  output logic        pld_req,
  byte_strm_if.src    strm
);

  logic        accept;
  logic        clr;
  logic        hdr_done;
  logic [15:0] byte_cnt;
  logic [15:0] req_cnt;
  logic [15:0] pld_len_q;
  logic [15:0] udp_len_q;
  logic [7:0]  pld_q;
  logic [7:0]  hdr_dat;
  udp_hdr_t    udp_hdr;

  assign accept = start && !busy && pld_len_ok(pld_len);

  // frame end clears everything, as a reset would
  assign clr = fsm_rst || strm.eof;

  assign udp_hdr.src_port = src_port;
  assign udp_hdr.dst_port = dst_port;
  assign udp_hdr.length   = pld_len + udp_hdr_len;
  assign udp_hdr.chksum   = 16'h0000;

  hdr_serializer #(
    .hdr_t (udp_hdr_t)
  ) u_hdr_ser (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .load    (accept),
    .hdr     (udp_hdr),
    .shift   (strm.val && !hdr_done),
    .dat     (hdr_dat)
  );

  always_ff @(posedge clk) begin
    if (clr) begin
      busy     <= 1'b0;
      udp_rdy  <= 1'b0;
      pld_req  <= 1'b0;
      strm.val <= 1'b0;
      hdr_done <= 1'b0;
      byte_cnt <= '0;
      req_cnt  <= '0;
    end
    else begin
      if (accept) busy <= 1'b1;
      if (busy) udp_rdy <= 1'b1;
      if (udp_go) strm.val <= 1'b1;
      if (strm.val) byte_cnt <= byte_cnt + 16'd1;
      // request one cycle early, payload goes through a register
      if (strm.val && byte_cnt == udp_hdr_len - 16'd2) begin
        pld_req <= 1'b1;
      end
      else if (pld_req && req_cnt == pld_len_q - 16'd1) begin
        pld_req <= 1'b0;
      end
      if (pld_req) req_cnt <= req_cnt + 16'd1;
      if (strm.val && byte_cnt == udp_hdr_len - 16'd1) hdr_done <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    pld_q <= pld_dat;
    if (accept) begin
      pld_len_q <= pld_len;
      udp_len_q <= pld_len + udp_hdr_len;
    end
  end

  assign strm.dat = hdr_done ? pld_q : hdr_dat;
  assign strm.sof = strm.val && (byte_cnt == 16'd0);
  assign strm.eof = strm.val && (byte_cnt == udp_len_q - 16'd1);

endmodule : udp_tx

`default_nettype wire

/* logic/ipv4_hdr_gen.sv */
`default_nettype none

module ipv4_hdr_gen
  import udp_tx_pkg::*;
(
  input  logic        clk,
  input  logic        fsm_rst,
  input  logic        start,
  input  logic        busy,
  input  ipv4_addr_t  src_ip,
  input  ipv4_addr_t  dst_ip,
  input  logic [15:0] ip_id,
  input  logic [15:0] pld_len,
  input  logic        done,
  output logic        hdr_rdy,
  output ipv4_hdr_t   hdr
);

  logic                       accept;
  logic                       clr;
  logic                       run;
  logic [3:0]                 step;
  logic [19:0]                sum;
  logic [hdr_words-1:0][15:0] words;

  assign accept = start && !busy && pld_len_ok(pld_len);
  assign clr    = fsm_rst || done;

  // chksum is still zero while the words are summed
  assign words = hdr;

  //////////////////////////////////////////////////////////////////////
  // step 0..9 sums, 10 folds, 11 complements
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (clr) begin
      run     <= 1'b0;
      step    <= '0;
      hdr_rdy <= 1'b0;
    end
    else if (accept) begin
      run  <= 1'b1;
      step <= '0;
    end
    else if (run) begin
      step <= step + 4'd1;
      if (step == 4'(hdr_words + 1)) begin
        run     <= 1'b0;
        hdr_rdy <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      hdr.ver      <= ipv4_ver;
      hdr.ihl      <= ipv4_ihl;
      hdr.qos      <= 8'h00;
      hdr.length   <= pld_len + udp_hdr_len + ipv4_hdr_len;
      hdr.id       <= ip_id;
      hdr.flags_fo <= 16'h0000;
      hdr.ttl      <= ipv4_ttl;
      hdr.proto    <= ipv4_proto_udp;
      hdr.chksum   <= 16'h0000;
      hdr.src_ip   <= src_ip;
      hdr.dst_ip   <= dst_ip;
      sum          <= '0;
    end
    else if (run) begin
      if (step < 4'(hdr_words)) begin
        sum <= sum + {4'h0, words[4'(hdr_words - 1) - step]};
      end
      else if (step == 4'(hdr_words)) begin
        sum <= {4'h0, sum[15:0]} + {16'h0000, sum[19:16]};
      end
      else begin
        // last end-around carry is at most one bit
        hdr.chksum <= ~(sum[15:0] + {15'h0000, sum[16]});
      end
    end
  end

endmodule : ipv4_hdr_gen

`default_nettype wire

/* logic/ipv4_tx.sv */
`default_nettype none

module ipv4_tx
  import udp_tx_pkg::*;
(
  input  logic        clk,
  input  logic        fsm_rst,
  input  logic        udp_rdy,
  input  logic        hdr_rdy,
  input  ipv4_hdr_t   hdr,
  output logic        udp_go,
  output logic [7:0]  out_dat,
  output logic        out_val,
  output logic        out_sof,
  output logic        out_eof,
  byte_strm_if.snk    udp
);

  typedef enum logic [1:0] {
    st_idle,
    st_hdr,
    st_wait,
    st_relay
  } state_t;

  state_t     state;
  logic [4:0] byte_cnt;
  logic       start_frame;
  logic       relay_sel;
  logic       clr;
  logic [7:0] hdr_dat;

  assign start_frame = (state == st_idle) && udp_rdy && hdr_rdy;
  assign clr         = fsm_rst || out_eof;

  hdr_serializer #(
    .hdr_t (ipv4_hdr_t)
  ) u_hdr_ser (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .load    (start_frame),
    .hdr     (hdr),
    .shift   (state == st_hdr),
    .dat     (hdr_dat)
  );

  always_ff @(posedge clk) begin
    if (clr) begin
      state    <= st_idle;
      byte_cnt <= '0;
      udp_go   <= 1'b0;
    end
    else begin
      // registered, so udp byte 0 lands right after ip byte 19
      udp_go <= (state == st_hdr) && (byte_cnt == 5'(ipv4_hdr_len - 16'd2));
      case (state)
        st_idle: begin
          if (start_frame) begin
            state    <= st_hdr;
            byte_cnt <= '0;
          end
        end
        st_hdr: begin
          byte_cnt <= byte_cnt + 5'd1;
          if (byte_cnt == 5'(ipv4_hdr_len - 16'd1)) state <= st_wait;
        end
        st_wait: begin
          if (udp.sof) state <= st_relay;
        end
        st_relay: begin
          // left on eof through clr
        end
        default: state <= st_idle;
      endcase
    end
  end

  // only the stream belonging to this frame is passed on
  assign relay_sel = (state == st_relay) || ((state == st_wait) && udp.sof);

  assign out_val = (state == st_hdr) || (relay_sel && udp.val);
  assign out_dat = relay_sel ? udp.dat : hdr_dat;
  assign out_sof = (state == st_hdr) && (byte_cnt == 5'd0);
  assign out_eof = relay_sel && udp.eof;

endmodule : ipv4_tx

`default_nettype wire

/* logic/udp_ipv4_tx_top.sv */
`default_nettype none

module udp_ipv4_tx_top
  import udp_tx_pkg::*;
(
  input  logic        clk,
  input  logic        fsm_rst,
  input  logic        start,
  input  ipv4_addr_t  src_ip,
  input  ipv4_addr_t  dst_ip,
  input  logic [15:0] src_port,
  input  logic [15:0] dst_port,
  input  logic [15:0] ip_id,
  input  logic [15:0] pld_len,
  input  logic [7:0]  pld_dat,
  output logic        busy,
  output logic        pld_req,
  output logic [7:0]  out_dat,
  output logic        out_val,
  output logic        out_sof,
  output logic        out_eof
);

  logic      udp_rdy;
  logic      hdr_rdy;
  logic      udp_go;
  ipv4_hdr_t hdr;

  byte_strm_if u_udp_strm ();

  udp_tx u_udp_tx (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .start    (start),
    .src_port (src_port),
    .dst_port (dst_port),
    .pld_len  (pld_len),
    .pld_dat  (pld_dat),
    .udp_go   (udp_go),
    .busy     (busy),
    .udp_rdy  (udp_rdy),
    .pld_req  (pld_req),
    .strm     (u_udp_strm.src)
  );

  // header build runs alongside the udp side
  ipv4_hdr_gen u_ipv4_hdr_gen (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .start   (start),
    .busy    (busy),
    .src_ip  (src_ip),
    .dst_ip  (dst_ip),
    .ip_id   (ip_id),
    .pld_len (pld_len),
    .done    (out_eof),
    .hdr_rdy (hdr_rdy),
    .hdr     (hdr)
  );

  ipv4_tx u_ipv4_tx (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .udp_rdy (udp_rdy),
    .hdr_rdy (hdr_rdy),
    .hdr     (hdr),
    .udp_go  (udp_go),
    .out_dat (out_dat),
    .out_val (out_val),
    .out_sof (out_sof),
    .out_eof (out_eof),
    .udp     (u_udp_strm.snk)
  );

endmodule : udp_ipv4_tx_top

`default_nettype wire

/* testbench/tb_udp_ipv4_tx_checker.sv */
`default_nettype none

module tb_udp_ipv4_tx_checker (
  input logic clk,
  input logic fsm_rst,
  input logic busy,
  input logic pld_req,
  input logic out_val,
  input logic out_sof,
  input logic out_eof
);

  int fail_cnt = 0;

  // sof opens a frame after an idle cycle
  sof_with_val: assert property (@(posedge clk) disable iff (fsm_rst)
    out_sof |-> out_val && !$past(out_val))
    else begin
      $error("out_sof seen without out_val or inside a frame");
      fail_cnt++;
    end

  // no gaps between sof and eof
  val_until_eof: assert property (@(posedge clk) disable iff (fsm_rst)
    (out_val && !out_eof) |=> out_val)
    else begin
      $error("out_val dropped inside a frame");
      fail_cnt++;
    end

  idle_after_eof: assert property (@(posedge clk) disable iff (fsm_rst)
    out_eof |=> !out_val)
    else begin
      $error("out_val still high after out_eof");
      fail_cnt++;
    end

  req_only_busy: assert property (@(posedge clk) disable iff (fsm_rst)
    $rose(pld_req) |-> busy)
    else begin
      $error("pld_req rose while busy was low");
      fail_cnt++;
    end

endmodule : tb_udp_ipv4_tx_checker

`default_nettype wire

/* testbench/tb_frame_monitor.sv */
`default_nettype none

module tb_frame_monitor
  import udp_tx_pkg::*;
(
  input logic        clk,
  input logic        fsm_rst,
  input logic        start,
  input logic [31:0] src_ip,
  input logic [31:0] dst_ip,
  input logic [15:0] src_port,
  input logic [15:0] dst_port,
  input logic [15:0] ip_id,
  input logic [15:0] pld_len,
  input logic [7:0]  pld_dat,
  input logic        busy,
  input logic        pld_req,
  input logic [7:0]  out_dat,
  input logic        out_val,
  input logic        out_sof,
  input logic        out_eof
);

  // first byte leaves this many cycles after the accepting edge
  localparam int sof_lat   = 13;
  localparam int hdr_bytes = 28;

  int         err_cnt   = 0;
  int         frame_cnt = 0;
  int         frame_err = 0;
  int         cyc       = 0;
  int         total     = 0;
  int         cur_len   = 0;
  int         pld_n     = 0;
  int         pos       = 0;
  logic       active    = 1'b0;
  logic       was_active;
  logic       exp_val;
  logic [7:0] exp_hdr [0:hdr_bytes-1];
  logic [7:0] pld_exp [0:max_pld_len-1];

  task automatic check_sig(input string name, input logic [7:0] exp, input logic [7:0] got);
    if (got !== exp) begin
      $display("Error: %s exp %h got %h (frame %0d, byte %0d)",
               name, exp, got, frame_cnt, pos);
      err_cnt++;
    end
  endtask

  task automatic build_expected();
    logic [15:0] udp_len;
    logic [15:0] ip_len;
    logic [31:0] sum;
    int          k;
    udp_len = pld_len + 16'd8;
    ip_len  = udp_len + 16'd20;
    exp_hdr[0] = 8'h45;
    exp_hdr[1] = 8'h00;
    {exp_hdr[2], exp_hdr[3]} = ip_len;
    {exp_hdr[4], exp_hdr[5]} = ip_id;
    {exp_hdr[6], exp_hdr[7]} = 16'h0000;
    exp_hdr[8] = 8'd128;
    exp_hdr[9] = 8'd17;
    {exp_hdr[10], exp_hdr[11]} = 16'h0000;
    {exp_hdr[12], exp_hdr[13], exp_hdr[14], exp_hdr[15]} = src_ip;
    {exp_hdr[16], exp_hdr[17], exp_hdr[18], exp_hdr[19]} = dst_ip;
    // ones' complement sum over the ten header words
    sum = 32'h0;
    for (k = 0; k < 20; k += 2) begin
      sum = sum + {16'h0, exp_hdr[k], exp_hdr[k + 1]};
    end
    sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
    sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
    {exp_hdr[10], exp_hdr[11]} = ~sum[15:0];
    {exp_hdr[20], exp_hdr[21]} = src_port;
    {exp_hdr[22], exp_hdr[23]} = dst_port;
    {exp_hdr[24], exp_hdr[25]} = udp_len;
    {exp_hdr[26], exp_hdr[27]} = 16'h0000;
    cur_len = int'(pld_len);
    total   = hdr_bytes + cur_len;
  endtask

  //////////////////////////////////////////////////////////////////////
  // cycle model, sampled before the edge updates the dut
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (fsm_rst) begin
      if (active) begin
        $display("frame %0d: aborted by reset at cycle %0d", frame_cnt, cyc);
        frame_cnt++;
      end
      active = 1'b0;
    end
    else begin
      was_active = active;
      pos        = cyc - sof_lat;
      exp_val    = active && (pos >= 0) && (pos < total);
      check_sig("busy", active, busy);
      check_sig("out_val", exp_val, out_val);
      check_sig("out_sof", active && (pos == 0), out_sof);
      check_sig("out_eof", exp_val && (pos == total - 1), out_eof);
      // payload is requested from the last udp header byte on
      check_sig("pld_req", active && (pos >= 27) && (pos < 27 + cur_len), pld_req);
      if (pld_req && pld_n < int'(max_pld_len)) begin
        pld_exp[pld_n] = pld_dat;
        pld_n++;
      end
      if (exp_val) begin
        if (pos < hdr_bytes) begin
          check_sig("out_dat", exp_hdr[pos], out_dat);
        end
        else if (pos - hdr_bytes < pld_n) begin
          check_sig("out_dat", pld_exp[pos - hdr_bytes], out_dat);
        end
        else begin
          $display("payload byte %0d of frame %0d went out before it was requested",
                   pos - hdr_bytes, frame_cnt);
          err_cnt++;
        end
      end
      if (exp_val && pos == total - 1) begin
        if (err_cnt == frame_err) begin
          $display("frame %0d: %0d bytes, payload %0d, ok", frame_cnt, total, cur_len);
        end
        else begin
          $display("frame %0d: %0d bytes, payload %0d, %0d errors",
                   frame_cnt, total, cur_len, err_cnt - frame_err);
        end
        frame_cnt++;
        active = 1'b0;
      end
      if (active) begin
        cyc++;
      end
      if (start && !was_active) begin
        build_expected();
        active    = 1'b1;
        cyc       = 0;
        pld_n     = 0;
        frame_err = err_cnt;
      end
    end
  end

endmodule : tb_frame_monitor

`default_nettype wire

/* testbench/tb_udp_ipv4_tx.sv */
`default_nettype none

module tb_udp_ipv4_tx
  import udp_tx_pkg::*;
();

  logic        clk;
  logic        fsm_rst;
  logic        start;
  logic [31:0] src_ip;
  logic [31:0] dst_ip;
  logic [15:0] src_port;
  logic [15:0] dst_port;
  logic [15:0] ip_id;
  logic [15:0] pld_len;
  logic [7:0]  pld_dat = 8'h00;
  logic        busy;
  logic        pld_req;
  logic [7:0]  out_dat;
  logic        out_val;
  logic        out_sof;
  logic        out_eof;

  integer      seed;
  int          pld_idx  = 0;
  int          sent     = 0;
  int          timeouts = 0;
  logic [7:0]  pld_buf [0:max_pld_len-1];

  udp_ipv4_tx_top i_dut (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .start    (start),
    .src_ip   (src_ip),
    .dst_ip   (dst_ip),
    .src_port (src_port),
    .dst_port (dst_port),
    .ip_id    (ip_id),
    .pld_len  (pld_len),
    .pld_dat  (pld_dat),
    .busy     (busy),
    .pld_req  (pld_req),
    .out_dat  (out_dat),
    .out_val  (out_val),
    .out_sof  (out_sof),
    .out_eof  (out_eof)
  );

  tb_frame_monitor i_mon (.*);

  bind udp_ipv4_tx_top tb_udp_ipv4_tx_checker i_chk (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .busy    (busy),
    .pld_req (pld_req),
    .out_val (out_val),
    .out_sof (out_sof),
    .out_eof (out_eof)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // payload source, next byte for every cycle pld_req is high
  always @(negedge clk) begin
    if (!busy) begin
      pld_idx <= 0;
    end
    else if (pld_req) begin
      pld_dat <= pld_buf[pld_idx];
      pld_idx <= pld_idx + 1;
    end
  end

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic wait_busy_low(input int limit);
    int cnt;
    cnt = 0;
    while (busy !== 1'b0 && cnt < limit) begin
      @(negedge clk);
      cnt++;
    end
    if (busy !== 1'b0) begin
      $display("timeout: busy still high after %0d cycles", limit);
      timeouts++;
    end
  endtask

  task automatic fill_payload(input int len);
    int k;
    for (k = 0; k < len; k++) begin
      pld_buf[k] = 8'($random(seed));
    end
  endtask

  task automatic randomize_fields(input int len);
    src_ip   = $random(seed);
    dst_ip   = $random(seed);
    src_port = 16'($random(seed));
    dst_port = 16'($random(seed));
    ip_id    = 16'($random(seed));
    pld_len  = 16'(len);
  endtask

  task automatic pulse_start();
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
  endtask

  task automatic send_frame(input int len, input logic poke_busy);
    fill_payload(len);
    randomize_fields(len);
    pulse_start();
    sent++;
    // a second request in mid frame must be dropped
    if (poke_busy) begin
      wait_cycles(20);
      randomize_fields(1 + {$random(seed)} % 100);
      pulse_start();
    end
    wait_busy_low(len + 64);
  endtask

  task automatic reset_mid_frame(input int len, input int delay);
    fill_payload(len);
    randomize_fields(len);
    pulse_start();
    sent++;
    wait_cycles(delay);
    fsm_rst = 1'b1;
    wait_cycles(2);
    fsm_rst = 1'b0;
    wait_cycles(3);
  endtask

  initial begin
    int n;
    int errs;
    seed     = 32'h894c;
    fsm_rst  = 1'b1;
    start    = 1'b0;
    src_ip   = '0;
    dst_ip   = '0;
    src_port = '0;
    dst_port = '0;
    ip_id    = '0;
    pld_len  = 16'd1;
    wait_cycles(16);
    fsm_rst = 1'b0;
    wait_cycles(2);

    send_frame(1, 1'b0);
    send_frame(int'(max_pld_len), 1'b0);
    // back to back, each start as soon as busy falls
    for (n = 0; n < 8; n++) begin
      send_frame(1 + {$random(seed)} % 300, 1'b0);
    end
    send_frame(37, 1'b1);
    reset_mid_frame(200, 60);
    send_frame(64, 1'b0);
    wait_cycles(4);

    if (i_mon.frame_cnt != sent) begin
      $display("frame count wrong: %0d started, %0d seen", sent, i_mon.frame_cnt);
    end
    errs = i_mon.err_cnt + i_dut.i_chk.fail_cnt + timeouts + int'(i_mon.frame_cnt != sent);
    $display("frames %0d, compare errors %0d, assertion failures %0d, timeouts %0d",
             i_mon.frame_cnt, i_mon.err_cnt, i_dut.i_chk.fail_cnt, timeouts);
    if (errs == 0) begin
      $display("Testbench passed");
    end
    else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule : tb_udp_ipv4_tx

`default_nettype wire

/* vlog.f */
logic/udp_tx_pkg.sv
logic/byte_strm_if.sv
logic/hdr_serializer.sv
logic/udp_tx.sv
logic/ipv4_hdr_gen.sv
logic/ipv4_tx.sv
logic/udp_ipv4_tx_top.sv
testbench/tb_udp_ipv4_tx_checker.sv
testbench/tb_frame_monitor.sv
testbench/tb_udp_ipv4_tx.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_udp_ipv4_tx
FILELIST   := vlog.f
VFLAGS     := --binary --timing --assert -j 0 -Wno-fatal
LINT_FLAGS := --lint-only --timing --assert -Wall
OBJ_DIR    := obj_dir
LOG        := sim.log
RUN_ARGS   := +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "Testbench passed" $(LOG); then echo "simulation did not finish"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
